// File: design/mipsPkg.sv
`default_nettype none

package mipsPkg;

    localparam int dataWidth    = 32;
    localparam int addrWidth    = 32;
    localparam int regAddrWidth = 5;
    localparam int opWidth      = 6;
    localparam int immWidth     = 16;
    localparam int targetWidth  = 26;
    localparam int numRegs      = 1 << regAddrWidth;

    // primary opcodes
    localparam logic [opWidth-1:0] opR     = 6'h00;
    localparam logic [opWidth-1:0] opJ     = 6'h02;
    localparam logic [opWidth-1:0] opBeq   = 6'h04;
    localparam logic [opWidth-1:0] opBne   = 6'h05;
    localparam logic [opWidth-1:0] opAddi  = 6'h08;
    localparam logic [opWidth-1:0] opAddiu = 6'h09;
    localparam logic [opWidth-1:0] opLw    = 6'h23;
    localparam logic [opWidth-1:0] opSw    = 6'h2b;

    localparam logic [opWidth-1:0] fnAdd = 6'h20;  // only R-type kept

    localparam logic [addrWidth-1:0] excVector = 32'h100;

    typedef enum logic [3:0] {
        stFetch,
        stDecode,
        stAluRR,
        stAluImm,
        stMemAddr,
        stMemRead,
        stMemWrite,
        stWbAlu,
        stWbMem,
        stBranch,
        stJump,
        stExcept
    } ctrlState;

    typedef enum logic [1:0] {
        pcPlus4,
        pcBranch,
        pcJump,
        pcExc
    } pcSel;

    typedef enum logic {
        wbAlu,
        wbMem
    } wbSel;

endpackage

`default_nettype wire

// File: design/memBusIf.sv
`default_nettype none

interface memBus;
    import mipsPkg::*;

    logic                 reqValid;
    logic                 reqReady;
    logic [addrWidth-1:0] addr;
    logic [dataWidth-1:0] wdata;
    logic                 write;
    logic                 rspValid;  // single-cycle, also the write ack
    logic [dataWidth-1:0] rdata;

    modport requester (
        output reqValid, addr, wdata, write,
        input  reqReady, rspValid, rdata
    );

    modport arbiter (
        input  reqValid, addr, wdata, write,
        output reqReady, rspValid, rdata
    );

endinterface

`default_nettype wire

// File: design/mipsController.sv
`default_nettype none

module mipsController (
    input  logic                         clk,
    input  logic                         arstN,
    input  logic [mipsPkg::opWidth-1:0]  opcode,
    input  logic [mipsPkg::opWidth-1:0]  funct,
    input  logic                         overflow,
    input  logic                         zero,
    input  logic                         fetchDone,
    input  logic                         memDone,
    output logic                         fetchStart,
    output logic                         memStart,
    output logic                         memWrite,
    output logic                         regWrite,
    output logic                         aluSrcImm,
    output logic                         signedAdd,
    output mipsPkg::wbSel                wbSource,
    output logic                         regDstRd,
    output mipsPkg::pcSel                nextPc,
    output logic                         pcWrite,
    output logic                         loadAB,
    output logic                         aluOutWrite
);
    import mipsPkg::*;

    ctrlState state;
    ctrlState nextState;
    logic     booted;  // fetch of address 0 already issued

    always_comb begin
        nextState = state;
        case (state)
            stFetch:    if (fetchDone) nextState = stDecode;
            stDecode: begin
                case (opcode)
                    opR:             nextState = (funct == fnAdd) ? stAluRR : stExcept;
                    opAddi, opAddiu: nextState = stAluImm;
                    opLw, opSw:      nextState = stMemAddr;
                    opBeq, opBne:    nextState = stBranch;
                    opJ:             nextState = stJump;
                    default:         nextState = stExcept;  // unknown opcode
                endcase
            end
            stAluRR:    nextState = overflow ? stExcept : stWbAlu;
            stAluImm:   nextState = overflow ? stExcept : stWbAlu;  // addiu never flags
            stMemAddr:  nextState = (opcode == opSw) ? stMemWrite : stMemRead;
            stMemRead:  if (memDone) nextState = stWbMem;
            stMemWrite: if (memDone) nextState = stFetch;
            stWbAlu,
            stWbMem,
            stBranch,
            stJump,
            stExcept:   nextState = stFetch;
            default:    nextState = stFetch;
        endcase
    end

    // start pulses land in the first cycle of the wait state
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state      <= stFetch;
            booted     <= 1'b0;
            fetchStart <= 1'b0;
            memStart   <= 1'b0;
        end else begin
            state      <= nextState;
            booted     <= 1'b1;
            fetchStart <= (nextState == stFetch) && (state != stFetch || !booted);
            memStart   <= (state == stMemAddr);
        end
    end

    always_comb begin
        memWrite    = 1'b0;
        regWrite    = 1'b0;
        aluSrcImm   = 1'b0;
        signedAdd   = 1'b0;
        wbSource    = wbAlu;
        regDstRd    = 1'b0;
        nextPc      = pcPlus4;
        pcWrite     = 1'b0;
        loadAB      = 1'b0;
        aluOutWrite = 1'b0;
        case (state)
            stDecode: loadAB = 1'b1;
            stAluRR: begin
                signedAdd   = 1'b1;
                aluOutWrite = 1'b1;
            end
            stAluImm: begin
                aluSrcImm   = 1'b1;
                signedAdd   = (opcode == opAddi);
                aluOutWrite = 1'b1;
            end
            stMemAddr: begin
                aluSrcImm   = 1'b1;  // base + offset
                aluOutWrite = 1'b1;
            end
            stMemWrite: memWrite = 1'b1;
            stWbAlu: begin
                regWrite = 1'b1;
                regDstRd = (opcode == opR);
            end
            stWbMem: begin
                regWrite = 1'b1;
                wbSource = wbMem;
            end
            stBranch: begin
                nextPc  = pcBranch;
                pcWrite = (opcode == opBne) ? !zero : zero;
            end
            stJump: begin
                nextPc  = pcJump;
                pcWrite = 1'b1;
            end
            stExcept: begin
                nextPc  = pcExc;
                pcWrite = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: design/instrFetch.sv
`default_nettype none

module instrFetch (
    input  logic                             clk,
    input  logic                             arstN,
    memBus.requester                         bus,
    input  logic                             fetchStart,
    input  logic                             pcWrite,
    input  mipsPkg::pcSel                    nextPc,
    input  logic [mipsPkg::immWidth-1:0]     branchOffset,
    input  logic [mipsPkg::targetWidth-1:0]  jumpTarget,
    output logic                             fetchDone,
    output logic [mipsPkg::addrWidth-1:0]    pc,
    output logic [mipsPkg::dataWidth-1:0]    instr
);
    import mipsPkg::*;

    logic                 reqPending;
    logic                 rspWait;
    logic                 rspHit;
    logic [addrWidth-1:0] branchTarget;

    assign bus.reqValid = fetchStart | reqPending;
    assign bus.addr     = pc;
    assign bus.wdata    = '0;
    assign bus.write    = 1'b0;

    assign rspHit = rspWait & bus.rspValid;
    // pc already points past the branch here
    assign branchTarget = pc + {{(addrWidth-immWidth-2){branchOffset[immWidth-1]}},
                                branchOffset, 2'b00};

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            reqPending <= 1'b0;
            rspWait    <= 1'b0;
            fetchDone  <= 1'b0;
            pc         <= '0;
        end else begin
            reqPending <= bus.reqValid & ~bus.reqReady;
            if (rspHit)
                rspWait <= 1'b0;
            else if (bus.reqValid && bus.reqReady)
                rspWait <= 1'b1;
            fetchDone <= rspHit;
            if (rspHit) begin
                pc <= pc + addrWidth'(4);
            end else if (pcWrite) begin
                case (nextPc)
                    pcPlus4:  pc <= pc + addrWidth'(4);
                    pcBranch: pc <= branchTarget;
                    pcJump:   pc <= {pc[addrWidth-1:targetWidth+2], jumpTarget, 2'b00};
                    pcExc:    pc <= excVector;
                    default:  pc <= pc;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rspHit)
            instr <= bus.rdata;
    end

endmodule

`default_nettype wire

// File: design/loadStoreUnit.sv
`default_nettype none

module loadStoreUnit (
    input  logic                           clk,
    input  logic                           arstN,
    memBus.requester                       bus,
    input  logic                           memStart,
    input  logic                           memWrite,
    input  logic [mipsPkg::addrWidth-1:0]  addr,
    input  logic [mipsPkg::dataWidth-1:0]  storeData,
    output logic                           memDone,
    output logic [mipsPkg::dataWidth-1:0]  loadData
);

    logic reqPending;  // request raised, not yet accepted
    logic rspWait;
    logic rspHit;

    // addr and storeData come from ALUOut and B, both held by the FSM
    assign bus.reqValid = memStart | reqPending;
    assign bus.addr     = addr;
    assign bus.wdata    = storeData;
    assign bus.write    = memWrite;

    assign rspHit = rspWait & bus.rspValid;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            reqPending <= 1'b0;
            rspWait    <= 1'b0;
            memDone    <= 1'b0;
        end else begin
            reqPending <= bus.reqValid & ~bus.reqReady;
            if (rspHit)
                rspWait <= 1'b0;
            else if (bus.reqValid && bus.reqReady)
                rspWait <= 1'b1;
            memDone <= rspHit;
        end
    end

    always_ff @(posedge clk) begin
        if (rspHit && !memWrite)
            loadData <= bus.rdata;  // write acks carry no data
    end

endmodule

`default_nettype wire

// File: design/execUnit.sv
`default_nettype none

module execUnit (
    input  logic                           clk,
    input  logic                           arstN,
    input  logic [mipsPkg::dataWidth-1:0]  instr,
    input  logic                           regWrite,
    input  logic                           aluSrcImm,
    input  logic                           signedAdd,
    input  mipsPkg::wbSel                  wbSource,
    input  logic                           regDstRd,
    input  logic                           loadAB,
    input  logic                           aluOutWrite,
    input  logic [mipsPkg::dataWidth-1:0]  loadData,
    output logic [mipsPkg::dataWidth-1:0]  aluOut,
    output logic [mipsPkg::dataWidth-1:0]  storeData,
    output logic                           overflow,
    output logic                           zero
);
    import mipsPkg::*;

    localparam int msb = dataWidth - 1;

    logic [dataWidth-1:0]    regs [numRegs];
    logic [regAddrWidth-1:0] rs;
    logic [regAddrWidth-1:0] rt;
    logic [regAddrWidth-1:0] rd;
    logic [regAddrWidth-1:0] dest;
    logic [dataWidth-1:0]    rsVal;
    logic [dataWidth-1:0]    rtVal;
    logic [dataWidth-1:0]    a;
    logic [dataWidth-1:0]    b;
    logic [dataWidth-1:0]    immExt;
    logic [dataWidth-1:0]    aluB;
    logic [dataWidth-1:0]    sum;
    logic [dataWidth-1:0]    wbData;

    assign rs = instr[25:21];
    assign rt = instr[20:16];
    assign rd = instr[15:11];

    // $zero is never written, mask the read instead
    assign rsVal = (rs == '0) ? '0 : regs[rs];
    assign rtVal = (rt == '0) ? '0 : regs[rt];

    assign immExt = {{(dataWidth-immWidth){instr[immWidth-1]}}, instr[immWidth-1:0]};
    assign aluB   = aluSrcImm ? immExt : b;
    assign sum    = a + aluB;

    // same-sign operands, result sign flipped
    assign overflow = signedAdd & (a[msb] == aluB[msb]) & (sum[msb] != a[msb]);
    assign zero     = (a == b);

    assign dest      = regDstRd ? rd : rt;
    assign wbData    = (wbSource == wbMem) ? loadData : aluOut;
    assign storeData = b;

    always_ff @(posedge clk) begin
        if (regWrite && dest != '0)
            regs[dest] <= wbData;
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            a      <= '0;
            b      <= '0;
            aluOut <= '0;
        end else begin
            if (loadAB) begin
                a <= rsVal;
                b <= rtVal;
            end
            if (aluOutWrite)
                aluOut <= sum;
        end
    end

endmodule

`default_nettype wire

// File: design/memArbiter.sv
`default_nettype none

module memArbiter (
    input  logic                           clk,
    input  logic                           arstN,
    memBus.arbiter                         fetchBus,
    memBus.arbiter                         dataBus,
    output logic                           memReqValid,
    input  logic                           memReqReady,
    output logic [mipsPkg::addrWidth-1:0]  memAddr,
    output logic [mipsPkg::dataWidth-1:0]  memWdata,
    output logic                           memWrite,
    input  logic                           memRspValid,
    input  logic [mipsPkg::dataWidth-1:0]  memRdata
);

    logic held;       // accepted, response outstanding
    logic ownerData;
    logic waitValid;  // request stalled on ready last cycle
    logic waitData;
    logic selData;

    // a stalled request keeps the bus so its address stays put
    always_comb begin
        if (held)
            selData = ownerData;
        else if (waitValid)
            selData = waitData;
        else
            selData = dataBus.reqValid;  // data has priority
    end

    assign memReqValid = ~held & (selData ? dataBus.reqValid : fetchBus.reqValid);
    assign memAddr     = selData ? dataBus.addr : fetchBus.addr;
    assign memWdata    = selData ? dataBus.wdata : fetchBus.wdata;
    assign memWrite    = selData ? dataBus.write : fetchBus.write;

    assign dataBus.reqReady  = ~held & selData & memReqReady;
    assign fetchBus.reqReady = ~held & ~selData & memReqReady;

    assign dataBus.rspValid  = held & ownerData & memRspValid;
    assign fetchBus.rspValid = held & ~ownerData & memRspValid;
    assign dataBus.rdata     = memRdata;
    assign fetchBus.rdata    = memRdata;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            held      <= 1'b0;
            ownerData <= 1'b0;
            waitValid <= 1'b0;
            waitData  <= 1'b0;
        end else begin
            waitValid <= memReqValid & ~memReqReady;
            waitData  <= selData;
            if (memReqValid && memReqReady) begin
                held      <= 1'b1;
                ownerData <= selData;
            end else if (held && memRspValid) begin
                held <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: design/mipsCore.sv
`default_nettype none

module mipsCore (
    input  logic                           clk,
    input  logic                           arstN,
    output logic                           memReqValid,
    input  logic                           memReqReady,
    output logic [mipsPkg::addrWidth-1:0]  memAddr,
    output logic [mipsPkg::dataWidth-1:0]  memWdata,
    output logic                           memWrite,
    input  logic                           memRspValid,
    input  logic [mipsPkg::dataWidth-1:0]  memRdata
);
    import mipsPkg::*;

    memBus fetchBus ();
    memBus dataBus ();

    logic [dataWidth-1:0] instr;
    logic [dataWidth-1:0] aluOut;
    logic [dataWidth-1:0] storeData;
    logic [dataWidth-1:0] loadData;
    logic fetchStart, fetchDone, memStart, memDone, lsWrite;
    logic overflow, zero, pcWrite, loadAB, aluOutWrite;
    logic regWrite, aluSrcImm, signedAdd, regDstRd;
    wbSel wbSource;
    pcSel nextPc;

    mipsController ctrl (
        .clk, .arstN,
        .opcode(instr[31:26]), .funct(instr[5:0]),
        .overflow, .zero, .fetchDone, .memDone,
        .fetchStart, .memStart, .memWrite(lsWrite),
        .regWrite, .aluSrcImm, .signedAdd, .wbSource, .regDstRd,
        .nextPc, .pcWrite, .loadAB, .aluOutWrite
    );

    instrFetch fetch (
        .clk, .arstN, .bus(fetchBus.requester),
        .fetchStart, .pcWrite, .nextPc,
        .branchOffset(instr[immWidth-1:0]), .jumpTarget(instr[targetWidth-1:0]),
        .fetchDone, .pc(), .instr
    );

    loadStoreUnit lsu (
        .clk, .arstN, .bus(dataBus.requester),
        .memStart, .memWrite(lsWrite), .addr(aluOut), .storeData,
        .memDone, .loadData
    );

    execUnit exec (
        .clk, .arstN, .instr,
        .regWrite, .aluSrcImm, .signedAdd, .wbSource, .regDstRd,
        .loadAB, .aluOutWrite, .loadData,
        .aluOut, .storeData, .overflow, .zero
    );

    memArbiter arb (
        .clk, .arstN,
        .fetchBus(fetchBus.arbiter), .dataBus(dataBus.arbiter),
        .memReqValid, .memReqReady, .memAddr, .memWdata, .memWrite,
        .memRspValid, .memRdata
    );

endmodule

`default_nettype wire

// File: tb/memChecker.sv
`default_nettype none

module memChecker (
    input logic                           clk,
    input logic                           arstN,
    input logic                           memReqValid,
    input logic                           memReqReady,
    input logic [mipsPkg::addrWidth-1:0]  memAddr,
    input logic [mipsPkg::dataWidth-1:0]  memWdata,
    input logic                           memWrite
);
    timeunit 1ns;
    timeprecision 100ps;

    import mipsPkg::*;

    logic [addrWidth-1:0] expAddr [$];
    logic [dataWidth-1:0] expData [$];
    logic [addrWidth-1:0] faultPc;
    logic [addrWidth-1:0] handlerPc;
    logic                 afterFault;  // last fetch was the faulting word
    logic                 firstFetch;
    int                   storesSeen = 0;
    int                   errorCount = 0;

    task automatic startRow(input logic [addrWidth-1:0] fault,
                            input logic [addrWidth-1:0] handler);
        expAddr.delete();
        expData.delete();
        faultPc    = fault;
        handlerPc  = handler;
        afterFault = 1'b0;
        firstFetch = 1'b1;
        storesSeen = 0;
    endtask

    task automatic expectStore(input logic [addrWidth-1:0] addr,
                               input logic [dataWidth-1:0] data);
        expAddr.push_back(addr);
        expData.push_back(data);
    endtask

    // one accepted request per edge at most
    always @(posedge clk) begin
        if (arstN && memReqValid && memReqReady) begin
            if (memWrite) begin
                storesSeen++;
                if (expAddr.size() == 0) begin
                    $display("store of %h to %h was not expected", memWdata, memAddr);
                    errorCount++;
                end else begin
                    if (memAddr !== expAddr[0]) begin
                        $display("ERROR memAddr: store got %h, expected %h", memAddr, expAddr[0]);
                        errorCount++;
                    end
                    if (memWdata !== expData[0]) begin
                        $display("ERROR memWdata: got %h, expected %h", memWdata, expData[0]);
                        errorCount++;
                    end
                    void'(expAddr.pop_front());
                    void'(expData.pop_front());
                end
            end else begin
                if (firstFetch && memAddr !== '0) begin
                    $display("ERROR memAddr: first fetch got %h, expected %h", memAddr, 32'h0);
                    errorCount++;
                end
                if (afterFault && memAddr !== handlerPc) begin
                    $display("ERROR memAddr: fetch after fault got %h, expected %h",
                             memAddr, handlerPc);
                    errorCount++;
                end
                afterFault = (memAddr == faultPc);
                firstFetch = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: tb/mipsCore_properties.sv
`default_nettype none

module mipsCoreProperties (
    input logic                           clk,
    input logic                           arstN,
    input logic                           memReqValid,
    input logic                           memReqReady,
    input logic [mipsPkg::addrWidth-1:0]  memAddr,
    input logic                           memWrite,
    input logic                           memRspValid
);
    timeunit 1ns;
    timeprecision 100ps;

    logic outstanding;  // accepted, response not back yet
    int   assertFails = 0;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN)
            outstanding <= 1'b0;
        else if (memReqValid && memReqReady)
            outstanding <= 1'b1;
        else if (memRspValid)
            outstanding <= 1'b0;
    end

    reqStable: assert property (@(posedge clk) disable iff (!arstN)
        memReqValid && !memReqReady |=> $stable(memAddr) && $stable(memWrite))
        else begin
            $error("memAddr or memWrite changed while waiting for memReqReady");
            assertFails++;
        end

    validLowInReset: assert property (@(posedge clk) !arstN |-> !memReqValid)
        else begin
            $error("memReqValid high during reset");
            assertFails++;
        end

    singleOutstanding: assert property (@(posedge clk) disable iff (!arstN)
        outstanding |-> !(memReqValid && memReqReady))
        else begin
            $error("second request accepted before the response");
            assertFails++;
        end

endmodule

bind mipsCore mipsCoreProperties props (
    .clk, .arstN, .memReqValid, .memReqReady, .memAddr, .memWrite, .memRspValid
);

`default_nettype wire

// File: tb/mipsCoreTb.sv
`default_nettype none

module mipsCoreTb;
    timeunit 1ns;
    timeprecision 100ps;

    import mipsPkg::*;

    localparam int numRows     = 7;
    localparam int progLen     = 8;
    localparam int maxStores   = 3;
    localparam int memWords    = 256;
    localparam int resetCycles = 10;
    localparam int cycleLimit  = 2 * numRows * (progLen * 40 + resetCycles);
    localparam logic [31:0] noFault   = 32'hffff_ffff;
    localparam logic [31:0] handlerPc = 32'h100;

    // words from address 0, unused tails spin on beq $0,$0,-1
    localparam logic [31:0] progTable [numRows][progLen] = '{
        '{32'h2001_0005, 32'h2002_0007, 32'h0022_1820, 32'hac03_0200,   // addi, add, sw
          32'h2464_ffec, 32'hac04_0204, 32'h1000_ffff, 32'h1000_ffff},  // addiu -20
        '{32'h2001_1234, 32'hac01_0200, 32'h8c05_0200, 32'hac05_0204,   // sw, lw, sw
          32'h8c06_0208, 32'h24c7_ff00, 32'hac07_020c, 32'h1000_ffff},  // addiu past sign bit
        '{32'h2001_0003, 32'h2002_0003, 32'h1022_0001, 32'hac01_0200,   // beq taken
          32'h1020_0001, 32'hac02_0204, 32'h1000_ffff, 32'h1000_ffff},  // beq not taken
        '{32'h2001_0004, 32'h1420_0001, 32'hac01_0200, 32'h1421_0001,   // bne both ways
          32'hac01_0204, 32'h1000_ffff, 32'h1000_ffff, 32'h1000_ffff},
        '{32'h2001_0009, 32'h0800_0005, 32'hac01_0200, 32'hac01_0204,   // j 0x14
          32'h1000_ffff, 32'hac01_0208, 32'h1000_ffff, 32'h1000_ffff},
        '{32'h2002_0055, 32'h7c00_0000, 32'hac02_0200, 32'h1000_ffff,   // opcode 0x1f
          32'h1000_ffff, 32'h1000_ffff, 32'h1000_ffff, 32'h1000_ffff},
        '{32'h2002_0022, 32'h8c01_0208, 32'h2022_ff00, 32'hac02_0200,   // addi overflow
          32'h1000_ffff, 32'h1000_ffff, 32'h1000_ffff, 32'h1000_ffff}
    };
    localparam int storeCount [numRows] = '{2, 3, 1, 1, 1, 1, 1};
    localparam logic [31:0] storeAddr [numRows][maxStores] = '{
        '{32'h200, 32'h204, 32'h0}, '{32'h200, 32'h204, 32'h20c},
        '{32'h204, 32'h0, 32'h0},   '{32'h204, 32'h0, 32'h0},
        '{32'h208, 32'h0, 32'h0},   '{32'h214, 32'h0, 32'h0},
        '{32'h214, 32'h0, 32'h0}
    };
    localparam logic [31:0] storeData [numRows][maxStores] = '{
        '{32'h0000_000c, 32'hffff_fff8, 32'h0}, '{32'h1234, 32'h1234, 32'h7fff_ff82},
        '{32'h3, 32'h0, 32'h0},                 '{32'h4, 32'h0, 32'h0},
        '{32'h9, 32'h0, 32'h0},                 '{32'h55, 32'h0, 32'h0},
        '{32'h22, 32'h0, 32'h0}   // $2 keeps its value across the overflow
    };
    localparam logic [31:0] faultPc [numRows] = '{
        noFault, noFault, noFault, noFault, noFault, 32'h4, 32'h8
    };

    logic                 clk;
    logic                 arstN       = 1'b1;
    logic                 memReqValid;
    logic                 memReqReady = 1'b0;
    logic [addrWidth-1:0] memAddr;
    logic [dataWidth-1:0] memWdata;
    logic                 memWrite;
    logic                 memRspValid = 1'b0;
    logic [dataWidth-1:0] memRdata    = '0;

    logic [31:0] mem [memWords];
    logic        randomDelays = 1'b0;
    logic        busy         = 1'b0;
    logic        inReset      = 1'b0;  // reset as seen at the last rising edge
    int          rspDelay     = 0;
    logic [31:0] rspData      = '0;

    mipsCore dut (
        .clk, .arstN, .memReqValid, .memReqReady, .memAddr, .memWdata, .memWrite,
        .memRspValid, .memRdata
    );

    memChecker chk (
        .clk, .arstN, .memReqValid, .memReqReady, .memAddr, .memWdata, .memWrite
    );

    initial begin
        clk = 1'b1;  // first edge is a falling one
        forever #5 clk = ~clk;
    end

    always @(posedge clk)
        inReset <= !arstN;

    // memory model, answers 1 to 4 cycles after acceptance
    initial begin
        logic [7:0] idx;
        void'($urandom(32'hf849_d0de));
        forever begin
            @(negedge clk);
            memRspValid = 1'b0;
            if (inReset) begin
                busy        = 1'b0;
                memReqReady = 1'b0;
            end else begin
                if (busy && rspDelay == 0) begin
                    memRspValid = 1'b1;
                    memRdata    = rspData;
                    busy        = 1'b0;
                end else if (busy) begin
                    rspDelay--;
                end
                // ready toggles even with a request outstanding
                memReqReady = !randomDelays || $urandom_range(3) != 0;
                if (memReqValid && memReqReady && !busy) begin
                    idx = memAddr[9:2];
                    if (memWrite)
                        mem[idx] = memWdata;
                    rspData  = mem[idx];  // write ack echoes the word
                    rspDelay = randomDelays ? int'($urandom_range(3)) : 0;
                    busy     = 1'b1;
                end
            end
        end
    end

    task automatic loadMemory(input int row);
        for (int i = 0; i < memWords; i++)
            mem[i] = 32'h8000_0000 | i;
        for (int i = 0; i < progLen; i++)
            mem[i] = progTable[row][i];
        mem[handlerPc[9:2]]     = 32'hac02_0214;  // sw $2, 0x214($0)
        mem[handlerPc[9:2] + 1] = 32'h1000_ffff;
    endtask

    task automatic runRow(input int row);
        @(negedge clk);
        arstN = 1'b0;
        @(negedge clk);
        loadMemory(row);
        chk.startRow(faultPc[row], handlerPc);
        for (int i = 0; i < storeCount[row]; i++)
            chk.expectStore(storeAddr[row][i], storeData[row][i]);
        repeat (resetCycles - 1) @(negedge clk);
        arstN = 1'b1;
        while (chk.storesSeen < storeCount[row])
            @(negedge clk);
    endtask

    initial begin
        // zero delay first, then random stalls on the same table
        for (int pass = 0; pass < 2; pass++) begin
            randomDelays = (pass == 1);
            for (int row = 0; row < numRows; row++)
                runRow(row);
        end
        $display("memory port errors: %0d, assertion failures: %0d",
                 chk.errorCount, dut.props.assertFails);
        if (chk.errorCount == 0 && dut.props.assertFails == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

    initial begin
        int cycles;
        cycles = 0;
        while (cycles < cycleLimit) begin
            @(posedge clk);
            cycles++;
        end
        $display("simulation timed out after %0d cycles", cycles);
        $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
design/mipsPkg.sv
design/memBusIf.sv
design/mipsController.sv
design/instrFetch.sv
design/loadStoreUnit.sv
design/execUnit.sv
design/memArbiter.sv
design/mipsCore.sv
tb/memChecker.sv
tb/mipsCore_properties.sv
tb/mipsCoreTb.sv

// File: Bender.yml
package:
  name: mips_core

sources:
  - design/mipsPkg.sv
  - design/memBusIf.sv
  - design/mipsController.sv
  - design/instrFetch.sv
  - design/loadStoreUnit.sv
  - design/execUnit.sv
  - design/memArbiter.sv
  - design/mipsCore.sv
  - target: test
    files:
      - tb/memChecker.sv
      - tb/mipsCore_properties.sv
      - tb/mipsCoreTb.sv
